// ==== source/ldpc_settings.svh ====
`ifndef LDPC_SETTINGS_SVH
`define LDPC_SETTINGS_SVH

`define LDPC_CIRC        31
`define LDPC_BLOCK_ROWS  3
`define LDPC_BLOCK_COLS  5
`define LDPC_CODE_LEN    155

`define LDPC_INT_BITS    8
`define LDPC_FRAC_BITS   8
`define LDPC_LLR_MAG     11 // Raw value in the 8.8 format.

`define LDPC_MAX_ITER    30
`define LDPC_ITER_BITS   5

// Circulant shifts, row-major over the 3x5 block grid.
`define LDPC_SHIFT_0     1
`define LDPC_SHIFT_1     2
`define LDPC_SHIFT_2     4
`define LDPC_SHIFT_3     8
`define LDPC_SHIFT_4     16
`define LDPC_SHIFT_5     5
`define LDPC_SHIFT_6     10
`define LDPC_SHIFT_7     20
`define LDPC_SHIFT_8     9
`define LDPC_SHIFT_9     18
`define LDPC_SHIFT_10    25
`define LDPC_SHIFT_11    19
`define LDPC_SHIFT_12    7
`define LDPC_SHIFT_13    14
`define LDPC_SHIFT_14    28

`endif

// ==== source/ldpc_pkg.sv ====
`default_nettype none

`include "ldpc_settings.svh"

package ldpc_pkg;

	typedef logic signed [`LDPC_INT_BITS+`LDPC_FRAC_BITS-1:0] llr_t;
	typedef logic [$clog2(`LDPC_CIRC)-1:0] index_t;
	typedef logic [`LDPC_ITER_BITS-1:0] iter_t;
	typedef logic [`LDPC_CODE_LEN-1:0] word_t;

	typedef enum logic [2:0] {
		phase_idle,
		phase_syndrome,
		phase_variable,
		phase_check,
		phase_finished
	} phase_t;

	localparam index_t SHIFTS [`LDPC_BLOCK_ROWS*`LDPC_BLOCK_COLS] = '{
		`LDPC_SHIFT_0, `LDPC_SHIFT_1, `LDPC_SHIFT_2, `LDPC_SHIFT_3, `LDPC_SHIFT_4,
		`LDPC_SHIFT_5, `LDPC_SHIFT_6, `LDPC_SHIFT_7, `LDPC_SHIFT_8, `LDPC_SHIFT_9,
		`LDPC_SHIFT_10, `LDPC_SHIFT_11, `LDPC_SHIFT_12, `LDPC_SHIFT_13, `LDPC_SHIFT_14
	};

endpackage

`default_nettype wire

// ==== source/check_node.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_settings.svh"

module check_node (
	input wire ldpc_pkg::llr_t msg_in [`LDPC_BLOCK_COLS],
	output ldpc_pkg::llr_t msg_out [`LDPC_BLOCK_COLS]
);

	localparam int deg = `LDPC_BLOCK_COLS;
	localparam int msg_w = `LDPC_INT_BITS + `LDPC_FRAC_BITS;
	localparam int idx_w = $clog2(deg);

	logic [msg_w-1:0] mag [deg];
	logic [msg_w-1:0] min1;
	logic [msg_w-1:0] min2;
	logic [msg_w-1:0] out_mag;
	logic [idx_w-1:0] min_idx;
	logic sign_all;

	always_comb begin
		min1 = '1;
		min2 = '1;
		min_idx = '0;
		sign_all = 1'b0;
		for (int i = 0; i < deg; i++) begin
			mag[i] = msg_in[i][msg_w-1] ? msg_w'(-msg_in[i]) : msg_w'(msg_in[i]);
			sign_all = sign_all ^ msg_in[i][msg_w-1];
			if (mag[i] < min1) begin
				min2 = min1;
				min1 = mag[i];
				min_idx = idx_w'(i);
			end else if (mag[i] < min2) begin
				min2 = mag[i];
			end
		end

		// Excluding its own input, only the smallest edge sees the runner-up.
		for (int i = 0; i < deg; i++) begin
			out_mag = (min_idx == idx_w'(i)) ? min2 : min1;
			msg_out[i] = (sign_all ^ msg_in[i][msg_w-1]) ?
				-ldpc_pkg::llr_t'(out_mag) : ldpc_pkg::llr_t'(out_mag);
		end
	end

endmodule

`default_nettype wire

// ==== source/variable_node.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_settings.svh"

module variable_node (
	input wire ldpc_pkg::llr_t channel,
	input wire ldpc_pkg::llr_t msg_in [`LDPC_BLOCK_ROWS],
	output ldpc_pkg::llr_t msg_out [`LDPC_BLOCK_ROWS],
	output logic hard_bit
);

	localparam int deg = `LDPC_BLOCK_ROWS;
	localparam int msg_w = `LDPC_INT_BITS + `LDPC_FRAC_BITS;
	localparam int sum_w = msg_w + 2;
	localparam logic signed [sum_w-1:0] sat_max = sum_w'(2 ** (msg_w - 1) - 1);
	localparam logic signed [sum_w-1:0] sat_min = -sat_max; // Symmetric range.

	logic signed [sum_w-1:0] belief;
	logic signed [sum_w-1:0] extrinsic [deg];

	always_comb begin
		belief = sum_w'(channel);
		for (int i = 0; i < deg; i++)
			belief = belief + sum_w'(msg_in[i]);

		for (int i = 0; i < deg; i++) begin
			extrinsic[i] = belief - sum_w'(msg_in[i]);
			if (extrinsic[i] > sat_max)
				msg_out[i] = ldpc_pkg::llr_t'(sat_max);
			else if (extrinsic[i] < sat_min)
				msg_out[i] = ldpc_pkg::llr_t'(sat_min);
			else
				msg_out[i] = ldpc_pkg::llr_t'(extrinsic[i]);
		end
	end

	assign hard_bit = belief[sum_w-1]; // Negative belief decides a one.

endmodule

`default_nettype wire

// ==== source/edge_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_settings.svh"

module edge_memory (
	input wire clk,
	input wire ldpc_pkg::phase_t phase,
	input wire ldpc_pkg::index_t pos,
	input wire ldpc_pkg::index_t wr_pos,
	input wire wr_en,
	input wire ldpc_pkg::llr_t wr_data [`LDPC_BLOCK_ROWS*`LDPC_BLOCK_COLS],
	output ldpc_pkg::llr_t rd_data [`LDPC_BLOCK_ROWS*`LDPC_BLOCK_COLS]
);

	localparam int circ = `LDPC_CIRC;
	localparam int circs = `LDPC_BLOCK_ROWS * `LDPC_BLOCK_COLS;

	// Row of a circulant that connects to the given column.
	function automatic ldpc_pkg::index_t col_to_row(ldpc_pkg::index_t col,
		ldpc_pkg::index_t shift);
		logic [$bits(ldpc_pkg::index_t):0] diff;
		diff = {1'b0, col} + ($bits(diff))'(circ) - {1'b0, shift};
		if (diff >= ($bits(diff))'(circ))
			diff = diff - ($bits(diff))'(circ);
		return ldpc_pkg::index_t'(diff);
	endfunction

	for (genvar k = 0; k < circs; k++) begin : g_circ
		ldpc_pkg::llr_t mem [circ];
		ldpc_pkg::index_t rd_addr;
		ldpc_pkg::index_t wr_addr;

		assign rd_addr = (phase == ldpc_pkg::phase_variable) ?
			col_to_row(pos, ldpc_pkg::SHIFTS[k]) : pos;
		assign wr_addr = (phase == ldpc_pkg::phase_variable) ?
			col_to_row(wr_pos, ldpc_pkg::SHIFTS[k]) : wr_pos;

		always_ff @(posedge clk) begin
			if (wr_en)
				mem[wr_addr] <= wr_data[k];
			rd_data[k] <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// ==== source/codeword_store.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_settings.svh"

module codeword_store (
	input wire clk,
	input wire rst,
	input wire load,
	input wire ldpc_pkg::word_t codeword,
	input wire ldpc_pkg::phase_t phase,
	input wire ldpc_pkg::index_t pos,
	input wire ldpc_pkg::index_t wr_pos,
	input wire wr_en,
	input wire [`LDPC_BLOCK_COLS-1:0] hard_bits,
	output ldpc_pkg::llr_t channel [`LDPC_BLOCK_COLS],
	output logic [`LDPC_BLOCK_ROWS-1:0] row_parity,
	output ldpc_pkg::word_t decoded
);

	localparam int circ = `LDPC_CIRC;
	localparam int rows = `LDPC_BLOCK_ROWS;
	localparam int cols = `LDPC_BLOCK_COLS;
	localparam ldpc_pkg::llr_t llr_pos = ldpc_pkg::llr_t'(`LDPC_LLR_MAG);
	localparam ldpc_pkg::llr_t llr_neg = -llr_pos;

	ldpc_pkg::word_t chan_bits;
	logic [cols-1:0] touched [rows];

	// Column within the circulant that a row connects to.
	function automatic ldpc_pkg::index_t row_to_col(ldpc_pkg::index_t row,
		ldpc_pkg::index_t shift);
		logic [$bits(ldpc_pkg::index_t):0] sum;
		sum = {1'b0, row} + {1'b0, shift};
		if (sum >= ($bits(sum))'(circ))
			sum = sum - ($bits(sum))'(circ);
		return ldpc_pkg::index_t'(sum);
	endfunction

	always_comb begin
		for (int i = 0; i < rows; i++)
			for (int j = 0; j < cols; j++)
				touched[i][j] = decoded[j*circ + int'(row_to_col(pos, ldpc_pkg::SHIFTS[i*cols + j]))];
	end

	// Registered to line up with the message memory read.
	always_ff @(posedge clk) begin
		if (load)
			chan_bits <= codeword;
		for (int i = 0; i < rows; i++)
			row_parity[i] <= ^touched[i];
		for (int j = 0; j < cols; j++)
			channel[j] <= chan_bits[j*circ + int'(pos)] ? llr_neg : llr_pos;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			decoded <= '0;
		end else if (load) begin
			decoded <= codeword;
		end else if (wr_en && phase == ldpc_pkg::phase_variable) begin
			for (int j = 0; j < cols; j++)
				decoded[j*circ + int'(wr_pos)] <= hard_bits[j];
		end
	end

endmodule

`default_nettype wire

// ==== source/decoder_control.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_settings.svh"

module decoder_control (
	input wire clk,
	input wire rst,
	input wire start,
	input wire [`LDPC_BLOCK_ROWS-1:0] row_parity,
	output ldpc_pkg::phase_t phase,
	output ldpc_pkg::index_t pos,
	output ldpc_pkg::index_t wr_pos,
	output logic wr_en,
	output logic load,
	output logic busy,
	output logic done,
	output logic success,
	output ldpc_pkg::iter_t iterations
);

	localparam int circ = `LDPC_CIRC;
	localparam int step_bits = $clog2(circ + 2);
	localparam logic [step_bits-1:0] last_step = step_bits'(circ + 1);
	localparam ldpc_pkg::iter_t last_iter = ldpc_pkg::iter_t'(`LDPC_MAX_ITER - 1);

	logic [step_bits-1:0] step;
	logic syn_bad;
	logic active;
	logic check_rows;
	logic phase_end;

	assign active = (phase == ldpc_pkg::phase_syndrome) || (phase == ldpc_pkg::phase_variable) ||
		(phase == ldpc_pkg::phase_check);
	assign check_rows = (phase == ldpc_pkg::phase_syndrome) || (phase == ldpc_pkg::phase_check);
	assign phase_end = active && (step == last_step);

	assign pos = (step < step_bits'(circ)) ? ldpc_pkg::index_t'(step) : '0;
	assign load = start && (phase == ldpc_pkg::phase_idle);
	assign busy = (phase != ldpc_pkg::phase_idle);
	assign done = (phase == ldpc_pkg::phase_finished);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= ldpc_pkg::phase_idle;
			step <= '0;
			wr_pos <= '0;
			wr_en <= 1'b0;
			syn_bad <= 1'b0;
			success <= 1'b0;
			iterations <= '0;
		end else begin
			wr_pos <= pos; // Row or column whose read data returns next cycle.
			wr_en <= active && (step < step_bits'(circ));
			if (wr_en && check_rows && |row_parity)
				syn_bad <= 1'b1;

			case (phase)
				ldpc_pkg::phase_idle: begin
					if (start) begin
						phase <= ldpc_pkg::phase_syndrome;
						syn_bad <= 1'b0;
						success <= 1'b0;
						iterations <= '0;
					end
				end
				ldpc_pkg::phase_finished: begin
					phase <= ldpc_pkg::phase_idle;
				end
				default: begin
					step <= phase_end ? '0 : step + 1'b1;
					if (phase_end) begin
						syn_bad <= 1'b0;
						if (phase == ldpc_pkg::phase_syndrome) begin
							if (syn_bad) begin
								phase <= ldpc_pkg::phase_variable;
							end else begin
								phase <= ldpc_pkg::phase_finished;
								success <= 1'b1;
							end
						end else if (phase == ldpc_pkg::phase_variable) begin
							phase <= ldpc_pkg::phase_check;
						end else begin
							iterations <= iterations + 1'b1;
							if (!syn_bad) begin
								phase <= ldpc_pkg::phase_finished;
								success <= 1'b1;
							end else if (iterations == last_iter) begin
								phase <= ldpc_pkg::phase_finished; // Give up.
							end else begin
								phase <= ldpc_pkg::phase_variable;
							end
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/ldpc_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_settings.svh"

module ldpc_decoder (
	input wire clk,
	input wire rst,
	input wire start,
	input wire ldpc_pkg::word_t codeword,
	output logic busy,
	output logic done,
	output logic success,
	output ldpc_pkg::iter_t iterations,
	output ldpc_pkg::word_t decoded
);

	localparam int rows = `LDPC_BLOCK_ROWS;
	localparam int cols = `LDPC_BLOCK_COLS;
	localparam int circs = rows * cols;

	ldpc_pkg::phase_t phase;
	ldpc_pkg::index_t pos;
	ldpc_pkg::index_t wr_pos;
	logic wr_en;
	logic load;
	logic [rows-1:0] row_parity;
	logic [cols-1:0] hard_bits;

	ldpc_pkg::llr_t rd_data [circs];
	ldpc_pkg::llr_t wr_data [circs];
	ldpc_pkg::llr_t channel [cols];
	ldpc_pkg::llr_t cn_in [rows][cols];
	ldpc_pkg::llr_t cn_out [rows][cols];
	ldpc_pkg::llr_t vn_in [cols][rows];
	ldpc_pkg::llr_t vn_out [cols][rows];

	decoder_control u_control (
		.clk(clk),
		.rst(rst),
		.start(start),
		.row_parity(row_parity),
		.phase(phase),
		.pos(pos),
		.wr_pos(wr_pos),
		.wr_en(wr_en),
		.load(load),
		.busy(busy),
		.done(done),
		.success(success),
		.iterations(iterations)
	);

	edge_memory u_memory (
		.clk(clk),
		.phase(phase),
		.pos(pos),
		.wr_pos(wr_pos),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.rd_data(rd_data)
	);

	codeword_store u_store (
		.clk(clk),
		.rst(rst),
		.load(load),
		.codeword(codeword),
		.phase(phase),
		.pos(pos),
		.wr_pos(wr_pos),
		.wr_en(wr_en),
		.hard_bits(hard_bits),
		.channel(channel),
		.row_parity(row_parity),
		.decoded(decoded)
	);

	for (genvar i = 0; i < rows; i++) begin : g_row
		for (genvar j = 0; j < cols; j++) begin : g_col
			assign cn_in[i][j] = rd_data[i*cols + j];
			assign vn_in[j][i] = rd_data[i*cols + j];
			// Syndrome pass writes zeros, so messages start cleared.
			assign wr_data[i*cols + j] =
				(phase == ldpc_pkg::phase_check) ? cn_out[i][j] :
				(phase == ldpc_pkg::phase_variable) ? vn_out[j][i] : '0;
		end

		check_node u_check (
			.msg_in(cn_in[i]),
			.msg_out(cn_out[i])
		);
	end

	for (genvar j = 0; j < cols; j++) begin : g_var
		variable_node u_var (
			.channel(channel[j]),
			.msg_in(vn_in[j]),
			.msg_out(vn_out[j]),
			.hard_bit(hard_bits[j])
		);
	end

endmodule

`default_nettype wire

// ==== testbench/result_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_settings.svh"

module result_checker (
	input wire clk,
	input wire rst,
	input wire start,
	input wire busy,
	input wire done,
	input wire success,
	input wire ldpc_pkg::iter_t iterations,
	input wire ldpc_pkg::word_t decoded,
	input wire [8*16-1:0] exp_name,
	input wire ldpc_pkg::word_t exp_word,
	input wire [1:0] exp_success,
	input wire [7:0] min_iter,
	input wire [7:0] max_iter,
	output int tests_run,
	output int tests_failed,
	output int error_count
);

	localparam int circ = `LDPC_CIRC;
	localparam int rows = `LDPC_BLOCK_ROWS;
	localparam int cols = `LDPC_BLOCK_COLS;

	logic pending;
	int test_errors;

	// Row r of block row i sees column (r + shift) of each block column.
	function automatic logic [rows*circ-1:0] syndrome_of(ldpc_pkg::word_t word);
		logic [rows*circ-1:0] syn;
		int col;
		syn = '0;
		for (int i = 0; i < rows; i++)
			for (int r = 0; r < circ; r++)
				for (int j = 0; j < cols; j++) begin
					col = (r + int'(ldpc_pkg::SHIFTS[i*cols + j])) % circ;
					syn[i*circ + r] = syn[i*circ + r] ^ word[j*circ + col];
				end
		return syn;
	endfunction

	task automatic check_result();
		logic [rows*circ-1:0] syn;
		tests_run++;
		if (exp_success != 2'd2 && success != exp_success[0]) begin
			$display("ERROR %0s success expected %0d actual %0d", exp_name, exp_success, success);
			test_errors++;
		end
		if (exp_success == 2'd1 && decoded !== exp_word) begin
			$display("ERROR %0s decoded expected %h actual %h", exp_name, exp_word, decoded);
			test_errors++;
		end
		if (int'(iterations) < int'(min_iter) || int'(iterations) > int'(max_iter)) begin
			$display("ERROR %0s iterations expected %0d to %0d actual %0d",
				exp_name, min_iter, max_iter, iterations);
			test_errors++;
		end
		if (int'(iterations) > `LDPC_MAX_ITER) begin
			$display("ERROR %0s iterations expected at most %0d actual %0d",
				exp_name, `LDPC_MAX_ITER, iterations);
			test_errors++;
		end
		if (!success && int'(iterations) != `LDPC_MAX_ITER) begin
			$display("ERROR %0s iterations expected %0d actual %0d",
				exp_name, `LDPC_MAX_ITER, iterations);
			test_errors++;
		end
		if (success) begin
			syn = syndrome_of(decoded);
			if (syn != '0) begin
				$display("ERROR %0s syndrome expected 0 actual %h", exp_name, syn);
				test_errors++;
			end
		end
		error_count += test_errors;
		if (test_errors == 0) begin
			$display("PASS %0s: success %0d, iterations %0d", exp_name, success, iterations);
		end else begin
			tests_failed++;
			$display("FAIL %0s: %0d mismatches", exp_name, test_errors);
		end
		test_errors = 0;
	endtask

	initial begin
		pending = 1'b0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		error_count = 0;
	end

	always @(negedge clk) begin
		if (!rst) begin
			if (pending && !busy) begin
				$display("Protocol error: busy dropped before done in %0s", exp_name);
				error_count++;
				pending = 1'b0;
			end
			if (done) begin
				if (pending) begin
					check_result();
				end else begin
					$display("Protocol error: done pulse without an accepted start");
					error_count++;
				end
				pending = 1'b0;
			end
			if (start && !busy)
				pending = 1'b1; // Accepted start.
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_ldpc_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_settings.svh"

module tb_ldpc_decoder;

	localparam int max_tests = 32;
	localparam int phase_cycles = `LDPC_CIRC + 2;
	localparam int test_cycles = (`LDPC_MAX_ITER + 1) * 2 * phase_cycles;
	localparam int gap_cycles = 16; // Start pulses plus the idle gap.

	logic clk = 1'b0;
	logic rst;
	logic start;
	ldpc_pkg::word_t codeword;
	logic busy;
	logic done;
	logic success;
	ldpc_pkg::iter_t iterations;
	ldpc_pkg::word_t decoded;

	logic [8*16-1:0] exp_name;
	ldpc_pkg::word_t exp_word;
	logic [1:0] exp_success;
	logic [7:0] min_iter;
	logic [7:0] max_iter;
	int tests_run;
	int tests_failed;
	int error_count;

	logic [8*16-1:0] names [max_tests];
	ldpc_pkg::word_t inputs [max_tests];
	ldpc_pkg::word_t outputs [max_tests];
	logic [1:0] successes [max_tests];
	logic [7:0] min_iters [max_tests];
	logic [7:0] max_iters [max_tests];
	int num_tests = 0;
	int cycle_limit = 0;
	int cycles = 0;

	always #2 clk = ~clk;

	ldpc_decoder DUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.codeword(codeword),
		.busy(busy),
		.done(done),
		.success(success),
		.iterations(iterations),
		.decoded(decoded)
	);

	result_checker u_checker (
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.done(done),
		.success(success),
		.iterations(iterations),
		.decoded(decoded),
		.exp_name(exp_name),
		.exp_word(exp_word),
		.exp_success(exp_success),
		.min_iter(min_iter),
		.max_iter(max_iter),
		.tests_run(tests_run),
		.tests_failed(tests_failed),
		.error_count(error_count)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, %0d of %0d tests finished",
				cycles, tests_run, num_tests);
			$display("Test failed");
			$finish;
		end
	end

	task automatic load_tests();
		int fd;
		int count;
		int succ;
		int lo;
		int hi;
		logic [8*256-1:0] line;
		logic [8*16-1:0] name;
		ldpc_pkg::word_t in_word;
		ldpc_pkg::word_t out_word;
		fd = $fopen("testbench/ldpc_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the test data file");
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				if ($fgets(line, fd) != 0) begin
					count = $sscanf(line, "%s %h %h %d %d %d",
						name, in_word, out_word, succ, lo, hi);
					if (count == 6 && num_tests < max_tests) begin // Skips comment lines.
						names[num_tests] = name;
						inputs[num_tests] = in_word;
						outputs[num_tests] = out_word;
						successes[num_tests] = 2'(succ);
						min_iters[num_tests] = 8'(lo);
						max_iters[num_tests] = 8'(hi);
						num_tests++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_test(input int t);
		exp_name = names[t];
		exp_word = outputs[t];
		exp_success = successes[t];
		min_iter = min_iters[t];
		max_iter = max_iters[t];
		@(posedge clk);
		start <= 1'b1;
		codeword <= inputs[t];
		@(posedge clk);
		start <= 1'b0;
		repeat (3) @(posedge clk);
		start <= 1'b1; // Lands while busy, so it must be dropped.
		codeword <= ~inputs[t];
		@(posedge clk);
		start <= 1'b0;
		do
			@(negedge clk);
		while (!done);
		@(posedge clk);
	endtask

	initial begin
		int gap;
		void'($urandom(82));
		rst = 1'b1;
		start = 1'b0;
		codeword = '0;
		exp_name = '0;
		exp_word = '0;
		exp_success = 2'd0;
		min_iter = 8'd0;
		max_iter = 8'd0;
		load_tests();
		cycle_limit = num_tests * (test_cycles + gap_cycles) + 8 + 64;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);
		for (int t = 0; t < num_tests; t++) begin
			run_test(t);
			gap = $urandom_range(1, 6);
			repeat (gap) @(posedge clk);
		end
		repeat (4) @(posedge clk);
		if (tests_run != num_tests)
			$display("Expected %0d results but saw %0d", num_tests, tests_run);
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (num_tests > 0 && tests_run == num_tests && error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/ldpc_testdata.txt ====
# name input_word expected_word success min_iter max_iter (words in hex)
# success 2 takes either outcome and then the decoded word is not compared
all_zero 0 0 1 0 0
two_columns 3fffffffffffffff 3fffffffffffffff 1 0 0
four_columns fffffffffffffffffffffffffffffff fffffffffffffffffffffffffffffff 1 0 0
error_bit0 1 0 1 1 3
error_bit154 400000000000000000000000000000000000000 0 1 1 3
error_bit5 3fffffffffffffdf 3fffffffffffffff 1 1 3
error_bit100 fffffefffffffffffffffffffffffff fffffffffffffffffffffffffffffff 1 1 3
error_bit140 10000fffffffffffffffffffffffffffffff fffffffffffffffffffffffffffffff 1 1 3
one_column 7fffffff 7ffffffffffffffffffffffffffffff80000000 1 1 3
heavy_count 0123456789abcdef0123456789abcdef0123456 0 2 0 30
heavy_stripes 3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3 0 2 0 30
heavy_mixed 6db6db6db6db6db6db6db6db6db6db6db6db6db 0 2 0 30

// ==== sources.f ====
+incdir+source
source/ldpc_pkg.sv
source/check_node.sv
source/variable_node.sv
source/edge_memory.sv
source/codeword_store.sv
source/decoder_control.sv
source/ldpc_decoder.sv
testbench/result_checker.sv
testbench/tb_ldpc_decoder.sv

// ==== Makefile ====
TOP = tb_ldpc_decoder

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module ldpc_decoder
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
